/* core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_RADDR_W 5

`define CORE_OP_SPECIAL 6'h00
`define CORE_OP_ADDI    6'h08
`define CORE_OP_ADDIU   6'h09
`define CORE_OP_SLTI    6'h0a
`define CORE_OP_ANDI    6'h0c
`define CORE_OP_ORI     6'h0d
`define CORE_OP_XORI    6'h0e
`define CORE_OP_LUI     6'h0f

// funct field of SPECIAL
`define CORE_FN_SLL  6'h00
`define CORE_FN_SRL  6'h02
`define CORE_FN_SRA  6'h03
`define CORE_FN_ADD  6'h20
`define CORE_FN_ADDU 6'h21
`define CORE_FN_SUB  6'h22
`define CORE_FN_SUBU 6'h23
`define CORE_FN_AND  6'h24
`define CORE_FN_OR   6'h25
`define CORE_FN_XOR  6'h26
`define CORE_FN_NOR  6'h27
`define CORE_FN_SLT  6'h2a
`define CORE_FN_SLTU 6'h2b

`endif

/* core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

	typedef struct packed {
		logic [5:0]                 opcode;
		logic [`CORE_RADDR_W-1:0] rs;
		logic [`CORE_RADDR_W-1:0] rt;
		logic [`CORE_RADDR_W-1:0] rd;
		logic [4:0]                 shamt;
		logic [5:0]                 funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]                 opcode;
		logic [`CORE_RADDR_W-1:0] rs;
		logic [`CORE_RADDR_W-1:0] rt;
		logic [15:0]                imm;
	} i_fmt_t;

	// the same word seen as R-type or I-type, opcode picks the view
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		alu_op_e                    alu_op;
		logic [31:0]                opa;
		logic [31:0]                opb;
		logic [4:0]                 shamt;
		logic [`CORE_RADDR_W-1:0] dest;
		logic                       wen;
		logic                       trap_ovf;
		logic                       illegal;
		instr_u                     instr;
	} ex_req_t;

	typedef struct packed {
		instr_u                     instr;
		logic [`CORE_RADDR_W-1:0] dest;
		logic                       wen;
		logic [31:0]                value;
		logic                       overflow;
		logic                       illegal;
	} commit_t;

	typedef struct packed {
		logic                       valid;
		logic [`CORE_RADDR_W-1:0] dest;
		logic [31:0]                value;
	} fwd_t;

endpackage

/* regfile.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module regfile (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [`CORE_RADDR_W-1:0] raddr_a,
	input  logic [`CORE_RADDR_W-1:0] raddr_b,
	output logic [31:0]                rdata_a,
	output logic [31:0]                rdata_b,
	input  logic                       wen,
	input  logic [`CORE_RADDR_W-1:0] waddr,
	input  logic [31:0]                wdata
);

	logic [31:0] regs [1 << `CORE_RADDR_W];

	// r0 is never written and always reads back as zero
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata_a = (raddr_a == '0) ? 32'h0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? 32'h0 : regs[raddr_b];

	// the result stage must never present a write with an undefined target
	property p_waddr_known;
		@(posedge clk) disable iff (!arst_n)
		wen |-> !$isunknown(waddr);
	endproperty

	a_waddr_known: assert property (p_waddr_known)
		else $error("regfile write with unknown address");

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_stage import core_pkg::*; (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  instr_u                     in_instr,
	input  logic                       advance,
	output logic [`CORE_RADDR_W-1:0] raddr_a,
	output logic [`CORE_RADDR_W-1:0] raddr_b,
	input  logic [31:0]                rdata_a,
	input  logic [31:0]                rdata_b,
	input  fwd_t                       ex_fwd,
	input  fwd_t                       res_fwd,
	output logic                       ex_valid,
	output ex_req_t                    ex_req
);

	ex_req_t     dec_req;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] imm_sext;
	logic [31:0] imm_zext;

	// the youngest producer wins, then the one waiting to retire
	function automatic logic [31:0] resolve(input logic [`CORE_RADDR_W-1:0] addr,
			input logic [31:0] rf_val, input fwd_t ex_f, input fwd_t res_f);
		logic [31:0] val;
		val = rf_val;
		if (addr != '0 && res_f.valid && res_f.dest == addr) begin
			val = res_f.value;
		end
		if (addr != '0 && ex_f.valid && ex_f.dest == addr) begin
			val = ex_f.value;
		end
		return val;
	endfunction

	assign in_ready = advance;
	assign raddr_a  = in_instr.r_fmt.rs;
	assign raddr_b  = in_instr.r_fmt.rt;

	assign rs_val   = resolve(raddr_a, rdata_a, ex_fwd, res_fwd);
	assign rt_val   = resolve(raddr_b, rdata_b, ex_fwd, res_fwd);
	assign imm_sext = {{16{in_instr.i_fmt.imm[15]}}, in_instr.i_fmt.imm};
	assign imm_zext = {16'h0, in_instr.i_fmt.imm};

	always_comb begin
		dec_req       = '0;
		dec_req.instr = in_instr;
		dec_req.shamt = in_instr.r_fmt.shamt;
		dec_req.opa   = rs_val;
		dec_req.opb   = imm_sext;
		dec_req.dest  = in_instr.i_fmt.rt;
		dec_req.wen   = 1'b1;
		case (in_instr.r_fmt.opcode)
			`CORE_OP_SPECIAL: begin
				dec_req.opb  = rt_val;
				dec_req.dest = in_instr.r_fmt.rd;
				case (in_instr.r_fmt.funct)
					`CORE_FN_ADD:  begin
						dec_req.alu_op   = ALU_ADD;
						dec_req.trap_ovf = 1'b1;
					end
					`CORE_FN_ADDU: dec_req.alu_op = ALU_ADD;
					`CORE_FN_SUB:  begin
						dec_req.alu_op   = ALU_SUB;
						dec_req.trap_ovf = 1'b1;
					end
					`CORE_FN_SUBU: dec_req.alu_op = ALU_SUB;
					`CORE_FN_AND:  dec_req.alu_op = ALU_AND;
					`CORE_FN_OR:   dec_req.alu_op = ALU_OR;
					`CORE_FN_XOR:  dec_req.alu_op = ALU_XOR;
					`CORE_FN_NOR:  dec_req.alu_op = ALU_NOR;
					`CORE_FN_SLT:  dec_req.alu_op = ALU_SLT;
					`CORE_FN_SLTU: dec_req.alu_op = ALU_SLTU;
					`CORE_FN_SLL:  dec_req.alu_op = ALU_SLL;
					`CORE_FN_SRL:  dec_req.alu_op = ALU_SRL;
					`CORE_FN_SRA:  dec_req.alu_op = ALU_SRA;
					default:       dec_req.illegal = 1'b1;
				endcase
			end
			`CORE_OP_ADDI: begin
				dec_req.alu_op   = ALU_ADD;
				dec_req.trap_ovf = 1'b1;
			end
			`CORE_OP_ADDIU: dec_req.alu_op = ALU_ADD;
			`CORE_OP_SLTI:  dec_req.alu_op = ALU_SLT;
			`CORE_OP_ANDI: begin
				dec_req.alu_op = ALU_AND;
				dec_req.opb    = imm_zext;
			end
			`CORE_OP_ORI: begin
				dec_req.alu_op = ALU_OR;
				dec_req.opb    = imm_zext;
			end
			`CORE_OP_XORI: begin
				dec_req.alu_op = ALU_XOR;
				dec_req.opb    = imm_zext;
			end
			`CORE_OP_LUI: begin
				dec_req.alu_op = ALU_LUI;
				dec_req.opb    = imm_zext;
			end
			default: dec_req.illegal = 1'b1;
		endcase
		if (dec_req.illegal) begin
			dec_req.wen  = 1'b0;
			dec_req.dest = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else if (advance) begin
			ex_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_req <= dec_req;
		end
	end

	// a stalled word must keep its decode because the forwarding sources and registers hold
	a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid && !advance |=> $stable(dec_req))
		else $error("decoded request changed while stalled");

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module execute_stage import core_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    ex_valid,
	input  ex_req_t ex_req,
	input  logic    advance,
	output fwd_t    ex_fwd,
	output logic    res_valid,
	output commit_t res
);

	logic [31:0]                a;
	logic [31:0]                b;
	logic [31:0]                sum;
	logic [31:0]                diff;
	logic [31:0]                alu_res;
	logic [`CORE_RADDR_W-1:0] shift_amt;
	logic                       ovf;
	logic                       wen_eff;
	commit_t                    res_next;

	assign a         = ex_req.opa;
	assign b         = ex_req.opb;
	assign sum       = a + b;
	assign diff      = a - b;
	assign shift_amt = ex_req.shamt;

	always_comb begin
		case (ex_req.alu_op)
			ALU_ADD:  alu_res = sum;
			ALU_SUB:  alu_res = diff;
			ALU_AND:  alu_res = a & b;
			ALU_OR:   alu_res = a | b;
			ALU_XOR:  alu_res = a ^ b;
			ALU_NOR:  alu_res = ~(a | b);
			ALU_SLT:  alu_res = {31'h0, $signed(a) < $signed(b)};
			ALU_SLTU: alu_res = {31'h0, a < b};
			ALU_SLL:  alu_res = b << shift_amt;
			ALU_SRL:  alu_res = b >> shift_amt;
			ALU_SRA:  alu_res = $signed(b) >>> shift_amt;
			ALU_LUI:  alu_res = {b[15:0], 16'h0};
			default:  alu_res = 32'h0;
		endcase
	end

	// signed overflow when both inputs agree in sign and the result does not
	always_comb begin
		ovf = 1'b0;
		if (ex_req.trap_ovf) begin
			if (ex_req.alu_op == ALU_SUB) begin
				ovf = (a[31] != b[31]) && (diff[31] != a[31]);
			end else begin
				ovf = (a[31] == b[31]) && (sum[31] != a[31]);
			end
		end
	end

	assign wen_eff = ex_req.wen && !ovf && !ex_req.illegal;

	assign ex_fwd.valid = ex_valid && wen_eff;
	assign ex_fwd.dest  = ex_req.dest;
	assign ex_fwd.value = alu_res;

	assign res_next.instr    = ex_req.instr;
	assign res_next.dest     = ex_req.dest;
	assign res_next.wen      = wen_eff;
	assign res_next.value    = ex_req.illegal ? 32'h0 : alu_res;
	assign res_next.overflow = ovf;
	assign res_next.illegal  = ex_req.illegal;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else if (advance) begin
			res_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			res <= res_next;
		end
	end

	// decode never asks for an overflow check on a word it could not decode
	a_ill_ovf: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> !(res.illegal && res.overflow))
		else $error("commit flagged both illegal and overflow");

endmodule

/* result_stage.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module result_stage import core_pkg::*; (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       res_valid,
	input  commit_t                    res,
	output logic                       advance,
	output fwd_t                       res_fwd,
	output logic                       commit_valid,
	input  logic                       commit_ready,
	output commit_t                    commit,
	output logic                       rf_wen,
	output logic [`CORE_RADDR_W-1:0] rf_waddr,
	output logic [31:0]                rf_wdata
);

	logic retire;
	logic writes;

	assign retire = res_valid && commit_ready;
	assign writes = res.wen && !res.overflow && !res.illegal;

	// the whole pipe moves only when this slot empties or is already empty
	assign advance      = !res_valid || commit_ready;
	assign commit_valid = res_valid;
	assign commit       = res;

	assign rf_wen   = retire && writes;
	assign rf_waddr = res.dest;
	assign rf_wdata = res.value;

	// covers the cycle before the register file has the value
	assign res_fwd.valid = res_valid && writes;
	assign res_fwd.dest  = res.dest;
	assign res_fwd.value = res.value;

	a_commit_hold: assert property (@(posedge clk) disable iff (!arst_n)
		commit_valid && !commit_ready |=> commit_valid && $stable(commit))
		else $error("commit changed under back-pressure");

endmodule

/* core_top.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top import core_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    in_valid,
	output logic    in_ready,
	input  instr_u  in_instr,
	output logic    commit_valid,
	input  logic    commit_ready,
	output commit_t commit
);

	logic                       advance;
	logic [`CORE_RADDR_W-1:0] raddr_a;
	logic [`CORE_RADDR_W-1:0] raddr_b;
	logic [31:0]                rdata_a;
	logic [31:0]                rdata_b;
	logic                       rf_wen;
	logic [`CORE_RADDR_W-1:0] rf_waddr;
	logic [31:0]                rf_wdata;
	fwd_t                       ex_fwd;
	fwd_t                       res_fwd;
	logic                       ex_valid;
	ex_req_t                    ex_req;
	logic                       res_valid;
	commit_t                    res;

	decode_stage decode_i (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.advance(advance),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
		.ex_fwd(ex_fwd), .res_fwd(res_fwd),
		.ex_valid(ex_valid), .ex_req(ex_req)
	);

	execute_stage execute_i (
		.clk(clk), .arst_n(arst_n),
		.ex_valid(ex_valid), .ex_req(ex_req), .advance(advance),
		.ex_fwd(ex_fwd), .res_valid(res_valid), .res(res)
	);

	result_stage result_i (
		.clk(clk), .arst_n(arst_n),
		.res_valid(res_valid), .res(res), .advance(advance), .res_fwd(res_fwd),
		.commit_valid(commit_valid), .commit_ready(commit_ready), .commit(commit),
		.rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
	);

	regfile regfile_i (
		.clk(clk), .arst_n(arst_n),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
		.wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
	);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// release lands just after an edge so the first active edge sees a clean reset
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

/* tb_core.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_core import core_pkg::*;;

	localparam int total_instr = 62 + 300 + 303 + 600;
	localparam logic [5:0] r_functs [13] = '{`CORE_FN_ADD, `CORE_FN_ADDU, `CORE_FN_SUB,
		`CORE_FN_SUBU, `CORE_FN_AND, `CORE_FN_OR, `CORE_FN_XOR, `CORE_FN_NOR, `CORE_FN_SLT,
		`CORE_FN_SLTU, `CORE_FN_SLL, `CORE_FN_SRL, `CORE_FN_SRA};
	localparam logic [5:0] i_ops [7] = '{`CORE_OP_ADDI, `CORE_OP_ADDIU, `CORE_OP_SLTI,
		`CORE_OP_ANDI, `CORE_OP_ORI, `CORE_OP_XORI, `CORE_OP_LUI};

	logic    clk;
	logic    arst_n;
	logic    in_valid;
	logic    in_ready;
	instr_u  in_instr;
	logic    commit_valid;
	logic    commit_ready;
	commit_t commit;

	logic [31:0] mregs [32];
	instr_u      prog_q [$];
	commit_t     exp_q [$];
	int          errors;
	int          accepted;
	int          retired;
	int          test_count;
	int          err0;

	tb_clock clock_i (.clk(clk), .arst_n(arst_n));

	core_top dut_i (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.commit_valid(commit_valid), .commit_ready(commit_ready), .commit(commit)
	);

	function automatic logic is_legal(input instr_u w);
		logic ok;
		ok = 1'b0;
		case (w.r_fmt.opcode)
			`CORE_OP_SPECIAL: begin
				case (w.r_fmt.funct)
					`CORE_FN_ADD, `CORE_FN_ADDU, `CORE_FN_SUB, `CORE_FN_SUBU, `CORE_FN_AND,
					`CORE_FN_OR, `CORE_FN_XOR, `CORE_FN_NOR, `CORE_FN_SLT, `CORE_FN_SLTU,
					`CORE_FN_SLL, `CORE_FN_SRL, `CORE_FN_SRA: ok = 1'b1;
					default: ok = 1'b0;
				endcase
			end
			`CORE_OP_ADDI, `CORE_OP_ADDIU, `CORE_OP_SLTI, `CORE_OP_ANDI, `CORE_OP_ORI,
			`CORE_OP_XORI, `CORE_OP_LUI: ok = 1'b1;
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	// a 33-bit sign-extended sum disagrees in its top two bits on overflow
	function automatic logic signed_overflow(input logic [31:0] a, input logic [31:0] b,
			input logic sub);
		logic [32:0] wide;
		if (sub) begin
			wide = {a[31], a} - {b[31], b};
		end else begin
			wide = {a[31], a} + {b[31], b};
		end
		return wide[32] != wide[31];
	endfunction

	// in-order ISA model that updates its own registers as each word is accepted
	task automatic model_step(input instr_u w, output commit_t e);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] r;
		logic        ovf;
		a = mregs[w.r_fmt.rs];
		b = mregs[w.r_fmt.rt];
		sx = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
		zx = {16'h0, w.i_fmt.imm};
		r = 32'h0;
		ovf = 1'b0;
		e = '0;
		e.instr = w;
		if (!is_legal(w)) begin
			e.illegal = 1'b1;
		end else begin
			if (w.r_fmt.opcode == `CORE_OP_SPECIAL) begin
				e.dest = w.r_fmt.rd;
				case (w.r_fmt.funct)
					`CORE_FN_ADD, `CORE_FN_ADDU: r = a + b;
					`CORE_FN_SUB, `CORE_FN_SUBU: r = a - b;
					`CORE_FN_AND:  r = a & b;
					`CORE_FN_OR:   r = a | b;
					`CORE_FN_XOR:  r = a ^ b;
					`CORE_FN_NOR:  r = ~(a | b);
					`CORE_FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					`CORE_FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
					`CORE_FN_SLL:  r = b << w.r_fmt.shamt;
					`CORE_FN_SRL:  r = b >> w.r_fmt.shamt;
					default:       r = $signed(b) >>> w.r_fmt.shamt;
				endcase
				if (w.r_fmt.funct == `CORE_FN_ADD) begin
					ovf = signed_overflow(a, b, 1'b0);
				end
				if (w.r_fmt.funct == `CORE_FN_SUB) begin
					ovf = signed_overflow(a, b, 1'b1);
				end
			end else begin
				e.dest = w.i_fmt.rt;
				case (w.i_fmt.opcode)
					`CORE_OP_ADDI, `CORE_OP_ADDIU: r = a + sx;
					`CORE_OP_SLTI: r = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
					`CORE_OP_ANDI: r = a & zx;
					`CORE_OP_ORI:  r = a | zx;
					`CORE_OP_XORI: r = a ^ zx;
					default:       r = {w.i_fmt.imm, 16'h0};
				endcase
				if (w.i_fmt.opcode == `CORE_OP_ADDI) begin
					ovf = signed_overflow(a, sx, 1'b0);
				end
			end
			e.value = r;
			e.overflow = ovf;
			e.wen = !ovf;
			if (!ovf && e.dest != '0) begin
				mregs[e.dest] = r;
			end
		end
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_write(input commit_t got, input commit_t want);
		compare_field("write instr", 32'(got.instr), 32'(want.instr));
		compare_field("write dest", 32'(got.dest), 32'(want.dest));
		compare_field("write wen", 32'(got.wen), 32'(want.wen));
		compare_field("write value", got.value, want.value);
		compare_field("write overflow", 32'(got.overflow), 32'(want.overflow));
		compare_field("write illegal", 32'(got.illegal), 32'(want.illegal));
	endtask

	task automatic check_overflow(input commit_t got, input commit_t want);
		compare_field("overflow instr", 32'(got.instr), 32'(want.instr));
		compare_field("overflow dest", 32'(got.dest), 32'(want.dest));
		compare_field("overflow wen", 32'(got.wen), 32'(want.wen));
		compare_field("overflow flag", 32'(got.overflow), 32'(want.overflow));
		compare_field("overflow illegal", 32'(got.illegal), 32'(want.illegal));
	endtask

	task automatic check_illegal(input commit_t got, input commit_t want);
		compare_field("illegal instr", 32'(got.instr), 32'(want.instr));
		compare_field("illegal wen", 32'(got.wen), 32'(want.wen));
		compare_field("illegal overflow", 32'(got.overflow), 32'(want.overflow));
		compare_field("illegal flag", 32'(got.illegal), 32'(want.illegal));
	endtask

	task automatic check_held(input commit_t got, input commit_t was, input logic still_valid);
		if (!still_valid) begin
			$display("ERROR at %0t: commit_valid dropped before the commit was taken", $time);
			errors++;
		end else if (got !== was) begin
			$display("FAILED at %0t: commit changed while waiting, %h then %h", $time, was, got);
			errors++;
		end
	endtask

	task automatic monitor_commits();
		commit_t want;
		commit_t held;
		logic    pending;
		pending = 1'b0;
		held = '0;
		forever begin
			@(posedge clk);
			if (pending) begin
				check_held(commit, held, commit_valid);
			end
			pending = commit_valid && !commit_ready;
			held = commit;
			if (commit_valid && commit_ready) begin
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: commit arrived with nothing outstanding", $time);
					errors++;
				end else begin
					want = exp_q.pop_front();
					retired++;
					if (want.illegal) begin
						check_illegal(commit, want);
					end else if (want.overflow) begin
						check_overflow(commit, want);
					end else begin
						check_write(commit, want);
					end
				end
			end
		end
	endtask

	// mostly r0 to r7 so that back-to-back dependencies are common
	function automatic logic [4:0] pick_reg();
		logic [31:0] t;
		t = $urandom;
		if ($urandom_range(0, 9) < 8) begin
			return {2'b00, t[2:0]};
		end
		return t[4:0];
	endfunction

	function automatic instr_u make_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i_fmt.opcode = op;
		w.i_fmt.rs = rs;
		w.i_fmt.rt = rt;
		w.i_fmt.imm = imm;
		return w;
	endfunction

	function automatic instr_u make_random(input int mode);
		instr_u      w;
		logic [31:0] t;
		logic [31:0] k;
		int          pick;
		pick = (mode == 2) ? int'($urandom_range(0, 9)) : ((mode == 0) ? 5 : 1);
		t = $urandom;
		if (pick == 0) begin
			// half of the illegal words keep SPECIAL and carry an unknown funct
			do begin
				t = $urandom;
				if (t[31]) begin
					t[31:26] = `CORE_OP_SPECIAL;
				end
				w = t;
			end while (is_legal(w));
		end else if (pick >= 5) begin
			k = $urandom_range(0, 12);
			w.r_fmt.opcode = `CORE_OP_SPECIAL;
			w.r_fmt.rs = pick_reg();
			w.r_fmt.rt = pick_reg();
			w.r_fmt.rd = pick_reg();
			w.r_fmt.shamt = t[4:0];
			w.r_fmt.funct = r_functs[k[3:0]];
		end else begin
			k = $urandom_range(0, 6);
			w = make_i(i_ops[k[2:0]], pick_reg(), pick_reg(), t[15:0]);
		end
		return w;
	endfunction

	task automatic issue_program(input int bp_pct);
		commit_t e;
		logic    taken;
		@(posedge clk);
		#2;
		in_instr = prog_q.pop_front();
		in_valid = 1'b1;
		while (in_valid) begin
			@(posedge clk);
			taken = in_ready;
			if (taken) begin
				model_step(in_instr, e);
				exp_q.push_back(e);
				accepted++;
			end
			#2;
			commit_ready = $urandom_range(0, 99) >= bp_pct;
			if (taken && prog_q.size() != 0) begin
				in_instr = prog_q.pop_front();
			end else if (taken) begin
				in_valid = 1'b0;
			end
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
			commit_ready = $urandom_range(0, 99) >= bp_pct;
		end
		commit_ready = 1'b1;
	endtask

	task automatic report_test(input string name, input int n, input int start_errors);
		test_count++;
		$display("test %0d %s: %0d instructions, %0d errors", test_count, name, n,
			errors - start_errors);
	endtask

	task automatic run_test(input string name, input int bp_pct);
		int n;
		n = prog_q.size();
		err0 = errors;
		issue_program(bp_pct);
		report_test(name, n, err0);
	endtask

	initial begin
		#(total_instr * 20 * 20);
		$display("ERROR: the run timed out before every instruction retired");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		logic [31:0] t;
		void'($urandom(32'hd6c3c947));
		in_valid = 1'b0;
		in_instr = '0;
		commit_ready = 1'b1;
		errors = 0;
		accepted = 0;
		retired = 0;
		test_count = 0;
		foreach (mregs[i]) begin
			mregs[i] = 32'h0;
		end
		@(posedge arst_n);
		fork
			monitor_commits();
		join_none
		err0 = errors;
		repeat (4) begin
			@(posedge clk);
			if (commit_valid !== 1'b0 || in_ready !== 1'b1) begin
				$display("FAILED at %0t: after reset commit_valid %b in_ready %b", $time,
					commit_valid, in_ready);
				errors++;
			end
		end
		report_test("reset state", 0, err0);
		// every register gets a known value before random programs read it
		for (int r = 1; r < 32; r++) begin
			t = $urandom;
			prog_q.push_back(make_i(`CORE_OP_LUI, 5'd0, 5'(r), t[31:16]));
			prog_q.push_back(make_i(`CORE_OP_ORI, 5'(r), 5'(r), t[15:0]));
		end
		run_test("register init", 0);
		repeat (300) prog_q.push_back(make_random(0));
		run_test("dependent r-type", 0);
		// r1 becomes the largest positive word so that the addi overflows
		prog_q.push_back(make_i(`CORE_OP_LUI, 5'd0, 5'd1, 16'h7fff));
		prog_q.push_back(make_i(`CORE_OP_ORI, 5'd1, 5'd1, 16'hffff));
		prog_q.push_back(make_i(`CORE_OP_ADDI, 5'd1, 5'd2, 16'h0001));
		repeat (300) prog_q.push_back(make_random(1));
		run_test("i-type with back-pressure", 30);
		repeat (600) prog_q.push_back(make_random(2));
		run_test("mixed with illegal and back-pressure", 30);
		$display("tests %0d, accepted %0d, retired %0d, errors %0d", test_count, accepted,
			retired, errors);
		if (errors == 0 && accepted == retired) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+.
core_pkg.sv
regfile.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
tb_clock.sv
tb_core.sv

/* Makefile */
TOP = tb_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "PASS: all tests" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
